/* design/vcore_pkg.sv */
package vcore_pkg;

    localparam int instr_w   = 32;
    localparam int reg_idx_w = 5;

    // major opcodes
    localparam logic [6:0] op_lui     = 7'b0110111;
    localparam logic [6:0] op_imm     = 7'b0010011;
    localparam logic [6:0] op_reg     = 7'b0110011;
    localparam logic [6:0] op_branch  = 7'b1100011;
    localparam logic [6:0] op_vect    = 7'h57;
    localparam logic [6:0] op_vstream = 7'b1111111; // custom extension slot
    localparam logic [6:0] op_system  = 7'b1110011;

    // funct3 inside op_vect
    localparam logic [2:0] funct_vmacc = 3'h0;
    localparam logic [2:0] funct_vmv   = 3'h5;
    localparam logic [2:0] funct_vset  = 3'h7;

    // funct12 0x105, all register fields zero
    localparam logic [instr_w-1:0] wfi_word = {12'h105, 5'd0, 3'd0, 5'd0, op_system};

    typedef enum logic [2:0] {
        s_lui,
        s_addi,
        s_bne,
        s_add,
        s_nop
    } scalar_op_t;

    typedef enum logic [1:0] {
        v_nop,
        v_vmv,
        v_vmacc,
        v_stream
    } vec_op_t;

endpackage

/* design/dec_if.sv */
`timescale 1ns/1ns

interface dec_if #(
    parameter int data_w    = 32,
    parameter int rf_addr_w = 8
);
    import vcore_pkg::*;

    scalar_op_t           scalar_op;
    logic [reg_idx_w-1:0] rs1;
    logic [reg_idx_w-1:0] rs2;
    logic [reg_idx_w-1:0] rd;
    logic [data_w-1:0]    imm;        // lui or addi immediate
    logic [11:0]          branch_imm; // offset in halfwords
    logic                 wen_scalar;
    vec_op_t              vec_op;
    logic [rf_addr_w-1:0] vr_addr;    // base of source vector
    logic [rf_addr_w-1:0] vw_addr;    // base of destination vector
    logic [4:0]           vmv_imm;
    logic [2:0]           vec_len;    // length code from vsetivli
    logic                 is_wfi;

    modport dec (output scalar_op, rs1, rs2, rd, imm, branch_imm, wen_scalar,
                 output vec_op, vr_addr, vw_addr, vmv_imm, vec_len, is_wfi);
    modport ctrl (input vec_op, scalar_op, branch_imm, vec_len, is_wfi);
    modport scal (input scalar_op, rs1, rs2, rd, imm, wen_scalar);
    modport vec (input vec_op, vr_addr, vw_addr, vmv_imm);

endinterface

/* design/isa_decoder.sv */
`timescale 1ns/1ns

module isa_decoder #(
    parameter int data_w    = 32,
    parameter int rf_addr_w = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [vcore_pkg::instr_w-1:0] instr,
    input  logic                          done_steady,
    output logic                          ap_done,
    dec_if.dec                            dec
);
    import vcore_pkg::*;

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic                 is_lui;
    logic                 is_addi;
    logic                 is_add;
    logic                 is_bne;
    logic                 is_vmacc;
    logic                 is_vmv;
    logic                 is_vset;
    logic                 is_stream;
    logic                 is_wfi_d;
    logic [2:0]           len_code;
    logic [4:0]           vs2_t;
    logic [31:0]          lui_imm;
    logic [31:0]          addi_imm;
    logic [rf_addr_w-1:0] vs2_ext;
    logic [rf_addr_w-1:0] vd_ext;
    int                   base_sh;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    assign is_lui    = (opcode == op_lui);
    assign is_addi   = (opcode == op_imm) && (funct3 == 3'b000);
    assign is_add    = (opcode == op_reg) && (funct3 == 3'b000) && (instr[31:25] == 7'd0);
    assign is_bne    = (opcode == op_branch) && (funct3 == 3'b001);
    assign is_vmacc  = (opcode == op_vect) && (funct3 == funct_vmacc);
    assign is_vmv    = (opcode == op_vect) && (funct3 == funct_vmv);
    assign is_vset   = (opcode == op_vect) && (funct3 == funct_vset);
    assign is_stream = (opcode == op_vstream);
    assign dec.is_wfi = (instr == wfi_word);

    assign dec.scalar_op = is_lui  ? s_lui  :
                           is_addi ? s_addi :
                           is_bne  ? s_bne  :
                           is_add  ? s_add  : s_nop;

    assign dec.vec_op = is_vmacc  ? v_vmacc :
                        is_vmv    ? v_vmv   :
                        is_stream ? v_stream : v_nop;

    // scalar fields
    assign dec.rs1 = instr[19:15];
    assign dec.rs2 = instr[24:20];
    assign dec.rd  = instr[11:7];
    assign lui_imm  = {instr[31:12], 12'd0};
    assign addi_imm = {{20{instr[31]}}, instr[31:20]};
    assign dec.imm  = is_addi ? addi_imm[data_w-1:0] : lui_imm[data_w-1:0];
    assign dec.branch_imm = {instr[31], instr[7], instr[30:25], instr[11:8]};
    assign dec.wen_scalar = is_lui | is_addi | is_add;
    assign dec.vmv_imm    = instr[19:15];

    // length code, picked up by the next instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            len_code <= 3'd7; // one element until configured
        end else if (is_vset) begin
            len_code <= instr[17:15];
        end
    end

    assign dec.vec_len = len_code;

    // streamout names its register in the vd slot
    assign vs2_t   = is_stream ? instr[11:7] : instr[24:20];
    assign vs2_ext = rf_addr_w'(vs2_t);
    assign vd_ext  = rf_addr_w'(instr[11:7]);

    // register number times vector length gives the base
    always_comb begin
        case (len_code)
            3'd0:    base_sh = rf_addr_w - 1;
            3'd1:    base_sh = rf_addr_w - 2;
            3'd2:    base_sh = rf_addr_w - 3;
            3'd3:    base_sh = rf_addr_w - 4;
            3'd4:    base_sh = rf_addr_w - 5;
            3'd5:    base_sh = rf_addr_w - 6;
            3'd6:    base_sh = rf_addr_w - 7;
            default: base_sh = rf_addr_w - 8; // stride of one
        endcase
    end

    assign dec.vr_addr = vs2_ext << base_sh;
    assign dec.vw_addr = vd_ext << base_sh;

    always_ff @(posedge clk) begin
        if (rst) begin
            is_wfi_d <= 1'b0;
        end else begin
            is_wfi_d <= dec.is_wfi;
        end
    end

    // rising edge of wfi only
    assign ap_done = dec.is_wfi & ~is_wfi_d & done_steady;

endmodule

/* design/seq_ctrl.sv */
`timescale 1ns/1ns

module seq_ctrl (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    dec_if.ctrl         ctrl,
    input  logic        branch_taken,
    input  logic        last_elem,
    output logic [31:0] pc,
    output logic        exec_en,
    output logic        vec_start,
    output logic        elem_active,
    output logic        done_steady
);
    import vcore_pkg::*;

    typedef enum logic [1:0] {idle, fetch_exec, vec_busy, halted} state_t;

    state_t      state;
    logic        is_vec;
    logic        take_branch;
    logic [31:0] branch_off;

    assign is_vec      = (ctrl.vec_op != v_nop);
    assign take_branch = (ctrl.scalar_op == s_bne) && branch_taken;
    assign branch_off  = {{19{ctrl.branch_imm[11]}}, ctrl.branch_imm, 1'b0};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            pc    <= '0;
        end else begin
            case (state)
                idle, halted: begin
                    if (start) begin
                        state <= fetch_exec;
                        pc    <= '0; // every run starts at the first word
                    end
                end
                fetch_exec: begin
                    if (ctrl.is_wfi) begin
                        state <= halted;
                    end else if (is_vec) begin
                        state <= vec_busy; // hold pc for the element cycles
                    end else if (take_branch) begin
                        pc <= pc + branch_off;
                    end else begin
                        pc <= pc + 32'd4;
                    end
                end
                vec_busy: begin
                    if (last_elem) begin
                        state <= fetch_exec;
                        pc    <= pc + 32'd4;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    assign exec_en     = (state == fetch_exec) && !is_vec && !ctrl.is_wfi;
    assign vec_start   = (state == fetch_exec) && is_vec;
    assign elem_active = (state == vec_busy);
    // low from vector issue through the last element
    assign done_steady = ((state == fetch_exec) && !is_vec) || (state == halted);

endmodule

/* design/elem_counter.sv */
`timescale 1ns/1ns

module elem_counter #(
    parameter int rf_addr_w = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 vec_start,
    input  logic [2:0]           vec_len,
    output logic [rf_addr_w-1:0] elem_idx,
    output logic                 last_elem
);

    localparam logic [rf_addr_w-1:0] one = rf_addr_w'(1);

    logic                 active;
    logic [rf_addr_w-1:0] last_idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= 1'b0;
            elem_idx <= '0;
            last_idx <= '0;
        end else if (vec_start) begin
            active   <= 1'b1;
            elem_idx <= '0;
            // 2^(rf_addr_w-1-k) elements
            last_idx <= (one << ((rf_addr_w - 1) - int'(vec_len))) - one;
        end else if (active) begin
            if (last_elem) begin
                active   <= 1'b0;
                elem_idx <= '0;
            end else begin
                elem_idx <= elem_idx + one;
            end
        end
    end

    assign last_elem = active && (elem_idx == last_idx);

endmodule

/* design/scalar_unit.sv */
`timescale 1ns/1ns

module scalar_unit #(
    parameter int data_w = 32
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              exec_en,
    dec_if.scal               scal,
    output logic              branch_taken,
    output logic [data_w-1:0] x1_value
);
    import vcore_pkg::*;

    logic [data_w-1:0] regs [32];
    logic [data_w-1:0] rs1_val;
    logic [data_w-1:0] rs2_val;
    logic [data_w-1:0] wr_val;

    // x0 is hardwired
    assign rs1_val = (scal.rs1 == '0) ? '0 : regs[scal.rs1];
    assign rs2_val = (scal.rs2 == '0) ? '0 : regs[scal.rs2];

    always_comb begin
        case (scal.scalar_op)
            s_lui:   wr_val = scal.imm;
            s_addi:  wr_val = rs1_val + scal.imm;
            s_add:   wr_val = rs1_val + rs2_val;
            default: wr_val = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (exec_en && scal.wen_scalar && (scal.rd != '0)) begin
            regs[scal.rd] <= wr_val;
        end
    end

    assign branch_taken = (scal.scalar_op == s_bne) && (rs1_val != rs2_val);
    assign x1_value     = regs[1]; // fixed first source of vmacc

endmodule

/* design/vector_unit.sv */
`timescale 1ns/1ns

module vector_unit #(
    parameter int data_w    = 32,
    parameter int rf_addr_w = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    dec_if.vec                   vec,
    input  logic                 elem_active,
    input  logic [rf_addr_w-1:0] elem_idx,
    input  logic [data_w-1:0]    x1_value,
    output logic                 stream_valid,
    output logic [data_w-1:0]    stream_data
);
    import vcore_pkg::*;

    logic [data_w-1:0]    vmem [2**rf_addr_w];
    logic [rf_addr_w-1:0] rd_addr;
    logic [rf_addr_w-1:0] wr_addr;
    logic [data_w-1:0]    src_val;
    logic [data_w-1:0]    acc_val;
    logic [data_w-1:0]    imm_ext;
    logic [data_w-1:0]    wr_val;
    logic                 mem_we;

    // element address within the vector
    assign rd_addr = vec.vr_addr + elem_idx;
    assign wr_addr = vec.vw_addr + elem_idx;

    assign src_val = vmem[rd_addr];
    assign acc_val = vmem[wr_addr];
    assign imm_ext = {{(data_w - 5){vec.vmv_imm[4]}}, vec.vmv_imm};

    always_comb begin
        case (vec.vec_op)
            v_vmv:   wr_val = imm_ext;
            v_vmacc: wr_val = acc_val + x1_value * src_val; // vd += x1 * vs2
            default: wr_val = acc_val;
        endcase
    end

    assign mem_we = elem_active && !rst &&
                    ((vec.vec_op == v_vmv) || (vec.vec_op == v_vmacc));

    always_ff @(posedge clk) begin
        if (mem_we) begin
            vmem[wr_addr] <= wr_val;
        end
    end

    // one element per cycle, no back-pressure
    assign stream_valid = elem_active && (vec.vec_op == v_stream);
    assign stream_data  = src_val;

endmodule

/* design/vcore_top.sv */
`timescale 1ns/1ns

module vcore_top #(
    parameter int data_w    = 32,
    parameter int rf_addr_w = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic [vcore_pkg::instr_w-1:0] instr,
    output logic [31:0]                   pc,
    output logic                          stream_valid,
    output logic [data_w-1:0]             stream_data,
    output logic                          ap_done
);

    logic                 branch_taken;
    logic                 exec_en;
    logic                 vec_start;
    logic                 elem_active;
    logic                 done_steady;
    logic                 last_elem;
    logic [data_w-1:0]    x1_value;
    logic [rf_addr_w-1:0] elem_idx;

    dec_if #(.data_w(data_w), .rf_addr_w(rf_addr_w)) dec_bus ();

    isa_decoder #(.data_w(data_w), .rf_addr_w(rf_addr_w)) u_decoder (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .done_steady (done_steady),
        .ap_done     (ap_done),
        .dec         (dec_bus.dec)
    );

    seq_ctrl u_seq (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .ctrl         (dec_bus.ctrl),
        .branch_taken (branch_taken),
        .last_elem    (last_elem),
        .pc           (pc),
        .exec_en      (exec_en),
        .vec_start    (vec_start),
        .elem_active  (elem_active),
        .done_steady  (done_steady)
    );

    elem_counter #(.rf_addr_w(rf_addr_w)) u_count (
        .clk       (clk),
        .rst       (rst),
        .vec_start (vec_start),
        .vec_len   (dec_bus.vec_len),
        .elem_idx  (elem_idx),
        .last_elem (last_elem)
    );

    scalar_unit #(.data_w(data_w)) u_scalar (
        .clk          (clk),
        .rst          (rst),
        .exec_en      (exec_en),
        .scal         (dec_bus.scal),
        .branch_taken (branch_taken),
        .x1_value     (x1_value)
    );

    vector_unit #(.data_w(data_w), .rf_addr_w(rf_addr_w)) u_vector (
        .clk          (clk),
        .rst          (rst),
        .vec          (dec_bus.vec),
        .elem_active  (elem_active),
        .elem_idx     (elem_idx),
        .x1_value     (x1_value),
        .stream_valid (stream_valid),
        .stream_data  (stream_data)
    );

endmodule

/* verif/vcore_checker.sv */
`timescale 1ns/1ns

module vcore_checker #(
    parameter int rf_addr_w = 8
) (
    input logic        clk,
    input logic        rst,
    input logic        start,
    input logic [31:0] pc,
    input logic        done_steady,
    input logic        vec_start,
    input logic        last_elem,
    input logic [2:0]  vec_len,
    input logic        stream_valid,
    input logic        ap_done
);

    int   fail_count = 0; // assertion failures so far
    int   elem_cnt;       // cycles since vec_start
    int   exp_len;
    logic done_seen;      // ap_done already pulsed in this run

    always_ff @(posedge clk) begin
        if (rst) begin
            elem_cnt <= 0;
            exp_len  <= 0;
        end else if (vec_start) begin
            elem_cnt <= 1;
            exp_len  <= 1 << (rf_addr_w - 1 - int'(vec_len)); // elements for this code
        end else if (last_elem) begin
            elem_cnt <= 0;
        end else if (elem_cnt != 0) begin
            elem_cnt <= elem_cnt + 1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done_seen <= 1'b0;
        end else if (start) begin
            done_seen <= 1'b0;
        end else if (ap_done) begin
            done_seen <= 1'b1;
        end
    end

    // element window runs from the cycle after vec_start to last_elem
    stream_quiet: assert property (@(posedge clk) (rst || elem_cnt == 0) |-> !stream_valid)
        else begin
            $error("stream_valid high in reset or outside the element cycles");
            fail_count++;
        end

    // pc only moves on the last element or on start
    pc_hold: assert property (@(posedge clk) disable iff (rst)
        (!done_steady && !last_elem && !start) |=> $stable(pc))
        else begin
            $error("pc changed while done_steady was low");
            fail_count++;
        end

    done_pulse: assert property (@(posedge clk) disable iff (rst) ap_done |-> !done_seen)
        else begin
            $error("ap_done pulsed more than once in a run");
            fail_count++;
        end

    len_match: assert property (@(posedge clk) disable iff (rst)
        last_elem |-> (elem_cnt == exp_len))
        else begin
            $error("last_elem does not match the vector length code");
            fail_count++;
        end

endmodule

bind vcore_top vcore_checker #(.rf_addr_w(rf_addr_w)) chk_i (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .pc           (pc),
    .done_steady  (done_steady),
    .vec_start    (vec_start),
    .last_elem    (last_elem),
    .vec_len      (dec_bus.vec_len),
    .stream_valid (stream_valid),
    .ap_done      (ap_done)
);

/* verif/vcore_tb.sv */
`timescale 1ns/1ns

module vcore_tb;
    import vcore_pkg::*;

    localparam int data_w    = 32;
    localparam int rf_addr_w = 8;
    // reset and the five programs take about 130 cycles
    localparam int max_cycles = 250;

    logic               clk;
    logic               rst;
    logic               start;
    logic [instr_w-1:0] instr;
    logic [31:0]        pc;
    logic               stream_valid;
    logic [data_w-1:0]  stream_data;
    logic               ap_done;

    logic [instr_w-1:0] rom [64];
    logic [31:0]        got [$];    // streamed elements of the current program
    logic [31:0]        want [$];
    int                 bursts [$]; // length of each stream_valid run
    logic               valid_q = 1'b0;
    int                 done_cnt = 0;
    int                 cycles = 0;
    int                 test_errs = 0;
    int                 tests_run = 0;
    int                 tests_failed = 0;
    logic [31:0]        seed = 32'd48;

    vcore_top #(.data_w(data_w), .rf_addr_w(rf_addr_w)) dut_i (.*);

    assign instr = rom[pc[7:2]]; // word arrives in the same cycle

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] sext5(input logic [4:0] v);
        return {{27{v[4]}}, v};
    endfunction

    function automatic logic [31:0] enc_vec(input logic [2:0] f3, input logic [4:0] vd,
                                            input logic [4:0] src1, input logic [4:0] vs2);
        return {7'd0, vs2, src1, f3, vd, op_vect};
    endfunction

    function automatic logic [31:0] enc_stream(input logic [4:0] vr);
        return {20'd0, vr, op_vstream};
    endfunction

    function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, op_lui};
    endfunction

    function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, op_imm};
    endfunction

    function automatic logic [31:0] enc_add(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
        return {7'd0, rs2, rs1, 3'b000, rd, op_reg};
    endfunction

    // byte offset, bit 0 is implied
    function automatic logic [31:0] enc_bne(input logic [4:0] rs1, input logic [4:0] rs2,
                                            input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11], op_branch};
    endfunction

    task automatic clear_rom();
        for (int i = 0; i < 64; i++) begin
            rom[i] <= {12'(i), 5'd0, 3'b000, 5'd0, op_imm}; // addi x0 with the index
        end
    endtask

    task automatic run_program();
        got.delete();
        bursts.delete();
        done_cnt = 0;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (done_cnt == 0) begin
            @(posedge clk);
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act == exp) else begin
            $display("** Error %s: expected %0h, actual %0h", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_stream(input string name);
        check_val({name, " element count"}, want.size(), got.size());
        for (int i = 0; i < want.size() && i < got.size(); i++) begin
            check_val($sformatf("%s element %0d", name, i), want[i], got[i]);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errs != 0) begin
            tests_failed++;
        end
        $display("%s: %s", name, (test_errs == 0) ? "ok" : "failed");
        test_errs = 0;
        want.delete();
    endtask

    // sample away from the driving edge
    always @(negedge clk) begin
        if (stream_valid) begin
            got.push_back(stream_data);
            if (!valid_q) begin
                bursts.push_back(1);
            end else begin
                bursts[bursts.size() - 1] = bursts[bursts.size() - 1] + 1;
            end
        end
        valid_q = stream_valid;
        if (ap_done) begin
            done_cnt++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        logic [4:0]  imm_a;
        logic [4:0]  imm_b;
        logic [11:0] lo;
        logic [19:0] hi;
        logic [31:0] x3_val;
        logic [31:0] x1_val;

        rst   = 1'b1;
        start = 1'b0;
        clear_rom();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // four copies of a random immediate
        seed  = lcg(seed);
        imm_a = seed[24:20];
        clear_rom();
        rom[0] <= enc_vec(funct_vset, 5'd0, 5'd5, 5'd0);
        rom[1] <= enc_vec(funct_vmv, 5'd1, imm_a, 5'd0);
        rom[2] <= enc_stream(5'd1);
        rom[3] <= wfi_word;
        run_program();
        repeat (4) want.push_back(sext5(imm_a));
        check_stream("vmv_stream");
        end_test("vmv_stream");

        // x1 built by lui, addi and add, then one vmacc
        seed   = lcg(seed);
        imm_a  = seed[24:20];
        imm_b  = seed[14:10];
        lo     = seed[11:0];
        seed   = lcg(seed);
        hi     = seed[31:12];
        x3_val = {hi, 12'd0} + {{20{lo[11]}}, lo};
        x1_val = x3_val + x3_val;
        clear_rom();
        rom[0] <= enc_vec(funct_vset, 5'd0, 5'd5, 5'd0);
        rom[1] <= enc_lui(5'd3, hi);
        rom[2] <= enc_addi(5'd3, 5'd3, lo);
        rom[3] <= enc_add(5'd1, 5'd3, 5'd3);
        rom[4] <= enc_vec(funct_vmv, 5'd2, imm_a, 5'd0);
        rom[5] <= enc_vec(funct_vmv, 5'd3, imm_b, 5'd0);
        rom[6] <= enc_vec(funct_vmacc, 5'd3, 5'd0, 5'd2);
        rom[7] <= enc_stream(5'd3);
        rom[8] <= wfi_word;
        run_program();
        repeat (4) want.push_back(sext5(imm_b) + x1_val * sext5(imm_a));
        check_stream("scalar_macc");
        end_test("scalar_macc");

        // bne repeats the vmacc three times
        seed  = lcg(seed);
        imm_a = seed[24:20];
        imm_b = seed[14:10];
        lo    = {4'd0, seed[7:0]};
        clear_rom();
        rom[0] <= enc_vec(funct_vset, 5'd0, 5'd6, 5'd0);
        rom[1] <= enc_addi(5'd1, 5'd0, lo);
        rom[2] <= enc_vec(funct_vmv, 5'd4, imm_a, 5'd0);
        rom[3] <= enc_vec(funct_vmv, 5'd5, imm_b, 5'd0);
        rom[4] <= enc_addi(5'd2, 5'd0, 12'd3);
        rom[5] <= enc_vec(funct_vmacc, 5'd5, 5'd0, 5'd4);
        rom[6] <= enc_addi(5'd2, 5'd2, 12'hfff);
        rom[7] <= enc_bne(5'd2, 5'd0, 13'h1ff8); // back to the vmacc
        rom[8] <= enc_stream(5'd5);
        rom[9] <= wfi_word;
        run_program();
        repeat (2) want.push_back(sext5(imm_b) + 32'd3 * ({20'd0, lo} * sext5(imm_a)));
        check_stream("branch_loop");
        end_test("branch_loop");

        seed  = lcg(seed);
        imm_a = seed[24:20];
        imm_b = seed[14:10];
        clear_rom();
        rom[0] <= enc_vec(funct_vset, 5'd0, 5'd7, 5'd0);
        rom[1] <= enc_vec(funct_vmv, 5'd6, imm_a, 5'd0);
        rom[2] <= enc_stream(5'd6);
        rom[3] <= enc_vec(funct_vset, 5'd0, 5'd6, 5'd0);
        rom[4] <= enc_vec(funct_vmv, 5'd6, imm_b, 5'd0);
        rom[5] <= enc_stream(5'd6);
        rom[6] <= wfi_word;
        run_program();
        want.push_back(sext5(imm_a));
        repeat (2) want.push_back(sext5(imm_b));
        check_stream("length_change");
        check_val("length_change bursts", 2, bursts.size());
        if (bursts.size() == 2) begin
            check_val("length_change first burst", 1, bursts[0]);
            check_val("length_change second burst", 2, bursts[1]);
        end
        end_test("length_change");

        seed  = lcg(seed);
        imm_a = seed[24:20];
        clear_rom();
        rom[0] <= enc_vec(funct_vset, 5'd0, 5'd5, 5'd0);
        rom[1] <= enc_vec(funct_vmv, 5'd7, imm_a, 5'd0);
        rom[2] <= enc_stream(5'd7);
        rom[3] <= wfi_word;
        rom[4] <= enc_stream(5'd7); // never reached once halted
        run_program();
        repeat (20) @(posedge clk);
        repeat (4) want.push_back(sext5(imm_a));
        check_stream("wfi_done");
        check_val("wfi_done ap_done pulses", 1, done_cnt);
        check_val("wfi_done halted pc", 32'd12, pc);
        end_test("wfi_done");

        $display("%0d tests, %0d failed, %0d checker failures", tests_run, tests_failed,
                 dut_i.chk_i.fail_count);
        if (tests_failed == 0 && dut_i.chk_i.fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* sources.f */
design/vcore_pkg.sv
design/dec_if.sv
design/isa_decoder.sv
design/seq_ctrl.sv
design/elem_counter.sv
design/scalar_unit.sv
design/vector_unit.sv
design/vcore_top.sv
verif/vcore_checker.sv
verif/vcore_tb.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the vcore testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert -Wno-fatal --top-module vcore_tb -f sources.f -o vcore_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# keep running past assertion errors so the testbench can report them
./obj_dir/vcore_sim +verilator+error+limit+1000 > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "PASS: all tests" "$log"; then
    exit 0
fi
exit 1
